//--- dv/if_stage_props.sv
//////////////////////////////////////////////////
// bound assertions on the if_stage bus and alert
//////////////////////////////////////////////////

`timescale 1ns/100ps

module if_stage_props import if_bus_pkg::*; (
  input logic       clk_i,
  input logic       rst_ni,
  input logic       pc_set_i,
  input instr_req_t instr_req_i,
  input instr_rsp_t instr_rsp_i,
  input logic       pc_mismatch_alert_i
);

  // a granted request still waiting for its rvalid
  logic outstanding_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      outstanding_q <= 1'b0;
    end else begin
      outstanding_q <= (outstanding_q & ~instr_rsp_i.rvalid) |
                       (instr_req_i.req & instr_rsp_i.gnt);
    end
  end

  addr_aligned: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_req_i.req |-> (instr_req_i.addr[1:0] == 2'b00))
    else $error("instruction request address is not word aligned");

  // a redirect may move the address before the grant
  addr_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (instr_req_i.req && !instr_rsp_i.gnt && !pc_set_i) |=>
    (instr_req_i.req && $stable(instr_req_i.addr)))
    else $error("instruction request dropped or moved before the grant");

  rvalid_granted: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_rsp_i.rvalid |-> outstanding_q)
    else $error("rvalid arrived with no outstanding grant");

  no_alert: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !pc_mismatch_alert_i)
    else $error("sequential pc alert raised");

endmodule

// attach to every if_stage instance
bind if_stage if_stage_props props_inst (
  .clk_i               (clk_i),
  .rst_ni              (rst_ni),
  .pc_set_i            (pc_set_i),
  .instr_req_i         (instr_req_o),
  .instr_rsp_i         (instr_rsp_i),
  .pc_mismatch_alert_i (pc_mismatch_alert_o)
);

//--- dv/tb_clock_gen.sv
//////////////////////////////////////////////////
// testbench clock and power-on reset
//////////////////////////////////////////////////

`timescale 1ns/100ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_no
);

  // 100 ns period
  initial begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o;
  end

  // reset held for 5 cycles, released on a falling edge
  initial begin
    rst_no = 1'b0;
    repeat (5) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

//--- dv/tb_if_stage.sv
//////////////////////////////////////////////////
// testbench for the instruction fetch stage
// bus responder, reference model and checks
//////////////////////////////////////////////////

`timescale 1ns/100ps

module tb_if_stage import if_ctrl_pkg::*, if_bus_pkg::*; ();

  logic        clk_i, rst_ni, pc_set_i, irq_int_i, id_in_ready_i, instr_valid_clear_i;
  logic [31:0] boot_addr_i, branch_target_ex_i, csr_mepc_i, csr_depc_i, csr_mtvec_i;
  logic [4:0]  irq_vec_i;
  pc_sel_e     pc_mux_i;
  exc_pc_sel_e exc_pc_mux_i;
  instr_rsp_t  instr_rsp_i;
  instr_req_t  instr_req_o;
  logic [31:0] pc_set_target_o, instr_rdata_id_o, pc_id_o;
  logic        csr_mtvec_init_o, instr_valid_id_o, instr_new_id_o, instr_fetch_err_o;
  logic        pc_mismatch_alert_o, if_busy_o;

  // responder state, model state and run statistics
  logic        pending, exp_valid;
  logic [31:0] paddr, rnd, exp_pc, boot_pc;
  logic [2:0]  err_sel;
  int unsigned gnt_wait, rv_wait, redirect_pct, ready_pct, clear_pct;
  int          errors, accepted, redirects, bus_errs, tests, errs0;

  // fetch side of the model, advanced once per clock edge
  logic        fetch_on, fetch_held, rsp_owed, rsp_stale, exp_load, exp_busy;

  tb_clock_gen clock_gen_inst (.clk_o(clk_i), .rst_no(rst_ni));

  if_stage if_stage_inst (.*);

  //////////////////////////////////////////////////
  // random numbers and reference rules
  //////////////////////////////////////////////////

  // two lcg steps, upper halves only
  function automatic logic [31:0] rand32();
    logic [15:0] hi;
    rnd = rnd * 32'd1664525 + 32'd1013904223;
    hi  = rnd[31:16];
    rnd = rnd * 32'd1664525 + 32'd1013904223;
    return {hi, rnd[31:16]};
  endfunction

  // memory word, mixes every address bit
  function automatic logic [31:0] mem_hash(input logic [31:0] a);
    logic [31:0] h;
    h = a * 32'h9E37_79B1;
    return h ^ (h >> 13) ^ 32'h5A5A_C3C3;
  endfunction

  // roughly one address in eight answers with a bus error
  function automatic logic err_rule(input logic [31:0] a);
    logic [31:0] h;
    h = mem_hash(a);
    return h[9:7] == err_sel;
  endfunction

  // next-pc rule for the current selects
  function automatic logic [31:0] target_model();
    logic [31:0] base, exc_pc, t;
    logic [4:0]  idx;
    base = csr_mtvec_i & 32'hFFFF_FF00;
    idx  = irq_int_i ? 5'd31 : irq_vec_i;
    case (exc_pc_mux_i)
      EXC_PC_IRQ:     exc_pc = base + {25'd0, idx, 2'b00};
      EXC_PC_DBD:     exc_pc = 32'h1A11_0800;
      EXC_PC_DBG_EXC: exc_pc = 32'h1A11_0808;
      default:        exc_pc = base;
    endcase
    case (pc_mux_i)
      PC_JUMP: t = branch_target_ex_i;
      PC_EXC:  t = exc_pc;
      PC_ERET: t = csr_mepc_i;
      PC_DRET: t = csr_depc_i;
      default: t = boot_addr_i;
    endcase
    return t & 32'hFFFF_FFFC;
  endfunction

  // word on offer, late responses and busy over the edge just passed
  task automatic model_fetch_edge();
    logic owed_next;
    exp_load  = fetch_held & id_in_ready_i & ~pc_set_i;
    owed_next = instr_rsp_i.gnt | (rsp_owed & ~instr_rsp_i.rvalid);
    if (pc_set_i) begin
      // redirect drops the held word, a response still owed is stale
      fetch_on   = 1'b1;
      fetch_held = 1'b0;
      rsp_stale  = owed_next;
    end else if (instr_rsp_i.rvalid) begin
      if (rsp_stale) begin
        rsp_stale = 1'b0;
      end else begin
        fetch_held = 1'b1;
      end
    end else if (exp_load) begin
      fetch_held = 1'b0;
    end
    rsp_owed = owed_next;
    exp_busy = fetch_on & ~fetch_held;
  endtask

  //////////////////////////////////////////////////
  // drivers
  //////////////////////////////////////////////////

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    errors++;
  endtask

  task automatic set_policy(input int unsigned redir, input int unsigned ready,
                            input int unsigned clear);
    redirect_pct = redir;
    ready_pct    = ready;
    clear_pct    = clear;
  endtask

  task automatic randomize_sources();
    boot_addr_i        = rand32();
    branch_target_ex_i = rand32();
    csr_mepc_i         = rand32();
    csr_depc_i         = rand32();
    csr_mtvec_i        = rand32();
    irq_vec_i          = 5'(rand32());
    irq_int_i          = (rand32() % 32'd4) == 32'd0;
    pc_mux_i           = pc_sel_e'(3'(rand32() % 32'd5));
    exc_pc_mux_i       = exc_pc_sel_e'(2'(rand32()));
  endtask

  // memory side of the bus, one step per falling edge
  task automatic respond_bus();
    if (instr_rsp_i.rvalid) begin
      instr_rsp_i.rvalid = 1'b0;
      instr_rsp_i.err    = 1'b0;
    end
    if (instr_rsp_i.gnt) begin
      instr_rsp_i.gnt = 1'b0;
      pending         = 1'b1;
      rv_wait         = rand32() % 32'd4;
    end
    if (pending) begin
      if (rv_wait == 0) begin
        instr_rsp_i.rvalid = 1'b1;
        instr_rsp_i.rdata  = mem_hash(paddr);
        instr_rsp_i.err    = err_rule(paddr);
        pending            = 1'b0;
      end else begin
        rv_wait--;
      end
    end else if (instr_req_o.req) begin
      if (gnt_wait == 0) begin
        instr_rsp_i.gnt = 1'b1;
        paddr           = instr_req_o.addr;
        gnt_wait        = rand32() % 32'd3;
      end else begin
        gnt_wait--;
      end
    end
  endtask

  //////////////////////////////////////////////////
  // one clock of checks and stimulus
  //////////////////////////////////////////////////

  task automatic run_cycle();
    @(negedge clk_i);
    model_fetch_edge();
    // registered outputs, settled since the rising edge
    if (pc_mismatch_alert_o !== 1'b0) begin
      report_mismatch("pc_mismatch_alert_o", {31'd0, pc_mismatch_alert_o}, 32'd0);
    end
    if (if_busy_o !== exp_busy) begin
      report_mismatch("if_busy_o", {31'd0, if_busy_o}, {31'd0, exp_busy});
    end
    if (instr_new_id_o !== exp_load) begin
      report_mismatch("instr_new_id_o", {31'd0, instr_new_id_o}, {31'd0, exp_load});
    end
    if (exp_load) begin
      if (pc_id_o !== exp_pc) report_mismatch("pc_id_o", pc_id_o, exp_pc);
      if (instr_rdata_id_o !== mem_hash(exp_pc)) begin
        report_mismatch("instr_rdata_id_o", instr_rdata_id_o, mem_hash(exp_pc));
      end
      if (instr_fetch_err_o !== err_rule(exp_pc)) begin
        report_mismatch("instr_fetch_err_o", {31'd0, instr_fetch_err_o},
                        {31'd0, err_rule(exp_pc)});
      end
      if (instr_fetch_err_o === 1'b1) bus_errs++;
      exp_pc = exp_pc + 32'd4;
      accepted++;
    end
    // valid sets with each load and holds until cleared
    exp_valid = exp_load | (exp_valid & ~instr_valid_clear_i);
    if (instr_valid_id_o !== exp_valid) begin
      report_mismatch("instr_valid_id_o", {31'd0, instr_valid_id_o}, {31'd0, exp_valid});
    end
    respond_bus();
    randomize_sources();
    pc_set_i            = (rand32() % 32'd100) < redirect_pct;
    id_in_ready_i       = (rand32() % 32'd100) < ready_pct;
    instr_valid_clear_i = (rand32() % 32'd100) < clear_pct;
    #1;
    if (pc_set_i) begin
      exp_pc = target_model();
      redirects++;
    end
    if (pc_set_target_o !== target_model()) begin
      report_mismatch("pc_set_target_o", pc_set_target_o, target_model());
    end
    if (csr_mtvec_init_o !== (pc_set_i && pc_mux_i == PC_BOOT)) begin
      report_mismatch("csr_mtvec_init_o", {31'd0, csr_mtvec_init_o},
                      {31'd0, pc_set_i && pc_mux_i == PC_BOOT});
    end
  endtask

  // runs until n instructions went through IF-ID
  task automatic run_stream(input string name, input int n_instr);
    int start;
    int t;
    start = accepted;
    t     = 0;
    while ((accepted - start) < n_instr && t < 100 * n_instr) begin
      run_cycle();
      t++;
    end
    if ((accepted - start) < n_instr) begin
      $display("%s: timed out, only %0d of %0d instructions reached ID",
               name, accepted - start, n_instr);
      errors++;
    end
    tests++;
    $display("test %s: %0d errors", name, errors - errs0);
  endtask

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////

  initial begin
    int t;
    rnd                 = 32'hbb66_b158;
    instr_rsp_i         = '0;
    pc_set_i            = 1'b0;
    id_in_ready_i       = 1'b0;
    instr_valid_clear_i = 1'b0;
    randomize_sources();
    {pending, exp_valid, paddr, exp_pc} = '0;
    {fetch_on, fetch_held, rsp_owed, rsp_stale, exp_load, exp_busy} = '0;
    {errors, accepted, redirects, bus_errs, tests} = '0;
    gnt_wait = 0;
    rv_wait  = 0;
    err_sel  = 3'(rand32());
    t        = 0;
    while (rst_ni !== 1'b1 && t < 20) begin
      @(posedge clk_i);
      t++;
    end
    if (rst_ni !== 1'b1) begin
      $display("reset was never released");
      errors++;
    end

    // boot, mtvec init pulse and first request address
    errs0 = errors;
    set_policy(0, 100, 0);
    @(negedge clk_i);
    if (instr_req_o.req !== 1'b0) report_mismatch("instr_req_o.req", {31'd0, instr_req_o.req}, 0);
    if (if_busy_o !== 1'b0) report_mismatch("if_busy_o", {31'd0, if_busy_o}, 0);
    randomize_sources();
    pc_mux_i = PC_BOOT;
    pc_set_i = 1'b1;
    #1;
    boot_pc = boot_addr_i & 32'hFFFF_FFFC;
    exp_pc  = boot_pc;
    if (csr_mtvec_init_o !== 1'b1) begin
      report_mismatch("csr_mtvec_init_o", {31'd0, csr_mtvec_init_o}, 32'd1);
    end
    if (pc_set_target_o !== boot_pc) report_mismatch("pc_set_target_o", pc_set_target_o, boot_pc);
    run_cycle();
    if (instr_req_o.req !== 1'b1) report_mismatch("instr_req_o.req", {31'd0, instr_req_o.req}, 1);
    if (instr_req_o.addr !== boot_pc) begin
      report_mismatch("instr_req_o.addr", instr_req_o.addr, boot_pc);
    end
    run_stream("boot", 4);

    errs0 = errors;
    set_policy(15, 100, 20);
    run_stream("target rule", 24);
    errs0 = errors;
    set_policy(0, 100, 50);
    run_stream("sequential fetch", 24);
    errs0 = errors;
    set_policy(0, 40, 30);
    run_stream("back-pressure", 24);
    errs0 = errors;
    set_policy(10, 70, 30);
    run_stream("redirect and bus errors", 32);
    errs0 = errors;
    set_policy(5, 60, 10);
    run_stream("valid and alert control", 24);

    $display("%0d tests, %0d instructions, %0d redirects, %0d bus errors, %0d errors",
             tests, accepted, redirects, bus_errs, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- if_stage.f
verilog/if_ctrl_pkg.sv
verilog/if_bus_pkg.sv
verilog/if_pc_select.sv
verilog/if_fetch_unit.sv
verilog/if_id_register.sv
verilog/if_stage.sv
dv/if_stage_props.sv
dv/tb_clock_gen.sv
dv/tb_if_stage.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the if_stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=obj_dir/sim_if_stage

verilator --binary --timing --assert -f if_stage.f --top-module tb_if_stage \
  -Mdir obj_dir -o sim_if_stage
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

# the run counts as passed only if the testbench printed its pass line
if grep -q "Test completed successfully" "$LOG"; then
  echo "PASS"
  exit 0
fi
echo "FAIL"
exit 1

//--- verilog/if_bus_pkg.sv
//////////////////////////////////////////////////
// packed structs for the instruction bus
// and for the fetch unit to IF-ID payload
//////////////////////////////////////////////////

package if_bus_pkg;

  //////////////////////////////////////////////////
  // instruction bus
  //////////////////////////////////////////////////

  // host side, address held stable until gnt
  typedef struct packed {
    logic        req;
    logic [31:0] addr;
  } instr_req_t;

  // device side
  // gnt accepts the request, rvalid returns the word
  // err is only meaningful together with rvalid
  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic [31:0] rdata;
    logic        err;
  } instr_rsp_t;

  //////////////////////////////////////////////////
  // fetch to ID
  //////////////////////////////////////////////////

  // one fetched word with its address and bus error flag
  // valid stays up until taken or redirected
  typedef struct packed {
    logic        valid;
    logic [31:0] rdata;
    logic [31:0] addr;
    logic        err;
  } fetch_out_t;

endpackage

//--- verilog/if_ctrl_pkg.sv
//////////////////////////////////////////////////
// control encodings for the instruction fetch stage
// next-pc and exception selects, fetch FSM states,
// fixed debug vectors and the pc step
//////////////////////////////////////////////////

package if_ctrl_pkg;

  //////////////////////////////////////////////////
  // selects
  //////////////////////////////////////////////////

  // source of the next fetch address
  typedef enum logic [2:0] {
    PC_BOOT,
    PC_JUMP,
    PC_EXC,
    PC_ERET,
    PC_DRET
  } pc_sel_e;

  // target of an exception, interrupt or debug entry
  typedef enum logic [1:0] {
    EXC_PC_EXC,
    EXC_PC_IRQ,
    EXC_PC_DBD,
    EXC_PC_DBG_EXC
  } exc_pc_sel_e;

  // fetch unit FSM
  typedef enum logic [2:0] {
    IDLE,
    REQ,
    WAIT,
    FLUSH,
    HOLD
  } fetch_state_e;

  //////////////////////////////////////////////////
  // fixed addresses and constants
  //////////////////////////////////////////////////

  // debug module halt and exception entry points
  localparam logic [31:0] DM_HALT_ADDR = 32'h1A11_0800;
  localparam logic [31:0] DM_EXC_ADDR  = 32'h1A11_0808;

  // all internal interrupts share the nmi slot of the vector table
  localparam logic [4:0]  IRQ_NM_VEC   = 5'd31;

  // word fetch only, so the pc always moves by one word
  localparam logic [31:0] INSTR_STEP   = 32'd4;

endpackage

//--- verilog/if_fetch_unit.sv
//////////////////////////////////////////////////
// word fetch FSM on the instruction bus
// one outstanding request, stale response flush,
// holds the fetched word until ID takes it
//////////////////////////////////////////////////

`timescale 1ns/100ps

module if_fetch_unit import if_ctrl_pkg::*, if_bus_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        redirect_i,
  input  logic [31:0] target_i,
  input  instr_rsp_t  bus_rsp_i,
  input  logic        ready_i,
  output instr_req_t  bus_req_o,
  output fetch_out_t  fetch_o,
  output logic        busy_o
);

  fetch_state_e state_q, state_d;

  // address of the word being requested or held
  logic [31:0]  addr_q, addr_d;

  // captured response
  logic [31:0]  rdata_q, rdata_d;
  logic         err_q, err_d;

  logic         rsp_pending;

  //////////////////////////////////////////////////
  // redirect bookkeeping
  //////////////////////////////////////////////////

  // a response is still owed after this edge when the request
  // is granted now, or when an accepted one has not returned yet
  assign rsp_pending = ((state_q == REQ) & bus_rsp_i.gnt) |
                       (((state_q == WAIT) | (state_q == FLUSH)) & ~bus_rsp_i.rvalid);

  //////////////////////////////////////////////////
  // next state
  //////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    addr_d  = addr_q;
    rdata_d = rdata_q;
    err_d   = err_q;

    unique case (state_q)
      // nothing to fetch before the first pc set
      IDLE: begin
        state_d = IDLE;
      end
      // keep req and addr up until granted
      REQ: begin
        if (bus_rsp_i.gnt) begin
          state_d = WAIT;
        end
      end
      // exactly one rvalid follows a grant
      WAIT: begin
        if (bus_rsp_i.rvalid) begin
          rdata_d = bus_rsp_i.rdata;
          err_d   = bus_rsp_i.err;
          state_d = HOLD;
        end
      end
      // swallow the response of the old stream
      FLUSH: begin
        if (bus_rsp_i.rvalid) begin
          state_d = REQ;
        end
      end
      // word on offer, step on once ID takes it
      HOLD: begin
        if (ready_i) begin
          addr_d  = addr_q + INSTR_STEP;
          state_d = REQ;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase

    // redirect wins over everything above
    if (redirect_i) begin
      addr_d  = target_i;
      state_d = rsp_pending ? FLUSH : REQ;
    end
  end

  //////////////////////////////////////////////////
  // registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      addr_q  <= '0;
      rdata_q <= '0;
      err_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      addr_q  <= addr_d;
      rdata_q <= rdata_d;
      err_q   <= err_d;
    end
  end

  //////////////////////////////////////////////////
  // outputs
  //////////////////////////////////////////////////

  // bus side
  assign bus_req_o.req  = (state_q == REQ);
  assign bus_req_o.addr = addr_q;

  // ID side, the held address is the one that was fetched
  assign fetch_o.valid  = (state_q == HOLD);
  assign fetch_o.rdata  = rdata_q;
  assign fetch_o.addr   = addr_q;
  assign fetch_o.err    = err_q;

  // idle and a parked word both count as not busy
  assign busy_o = (state_q != IDLE) & (state_q != HOLD);

endmodule

//--- verilog/if_id_register.sv
//////////////////////////////////////////////////
// IF-ID pipeline register
// valid and new tracking, fetch error flag,
// sequential pc check with mismatch alert
//////////////////////////////////////////////////

`timescale 1ns/100ps

module if_id_register import if_ctrl_pkg::*, if_bus_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  fetch_out_t  fetch_i,
  input  logic        id_in_ready_i,
  input  logic        pc_set_i,
  input  logic        instr_valid_clear_i,
  output logic        instr_valid_id_o,
  output logic        instr_new_id_o,
  output logic        instr_fetch_err_o,
  output logic [31:0] instr_rdata_id_o,
  output logic [31:0] pc_id_o,
  output logic        pc_mismatch_alert_o
);

  logic        load;
  logic        valid_q, valid_d;
  logic        new_q;
  logic        seq_q, seq_d;
  logic [31:0] pc_expect;

  // handshake with ID, a pc set squashes the word in flight
  assign load = fetch_i.valid & id_in_ready_i & ~pc_set_i;

  //////////////////////////////////////////////////
  // valid and new
  //////////////////////////////////////////////////

  // set by a load, held until ID clears it
  assign valid_d = load | (valid_q & ~instr_valid_clear_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      new_q   <= 1'b0;
    end else begin
      valid_q <= valid_d;
      // single cycle marker for a freshly loaded word
      new_q   <= load;
    end
  end

  assign instr_valid_id_o = valid_q;
  assign instr_new_id_o   = new_q;

  //////////////////////////////////////////////////
  // payload
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      instr_rdata_id_o  <= '0;
      pc_id_o           <= '0;
      instr_fetch_err_o <= 1'b0;
    end else if (load) begin
      instr_rdata_id_o  <= fetch_i.rdata;
      pc_id_o           <= fetch_i.addr;
      instr_fetch_err_o <= fetch_i.err;
    end
  end

  //////////////////////////////////////////////////
  // sequential pc check
  //////////////////////////////////////////////////

  // armed by any load, disarmed by control flow changes
  // and by bus errors, whose recovery path is not sequential
  assign seq_d = (seq_q | load) & ~pc_set_i & ~(fetch_i.valid & fetch_i.err);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      seq_q <= 1'b0;
    end else begin
      seq_q <= seq_d;
    end
  end

  assign pc_expect = pc_id_o + INSTR_STEP;

  // only words actually on offer are compared
  assign pc_mismatch_alert_o = seq_q & fetch_i.valid & (fetch_i.addr != pc_expect);

endmodule

//--- verilog/if_pc_select.sv
//////////////////////////////////////////////////
// next-pc selection
// exception and interrupt vector, fetch target mux,
// mtvec init request on boot
//////////////////////////////////////////////////

`timescale 1ns/100ps

module if_pc_select import if_ctrl_pkg::*; (
  input  pc_sel_e     pc_mux_i,
  input  logic        pc_set_i,
  input  exc_pc_sel_e exc_pc_mux_i,
  input  logic [4:0]  irq_vec_i,
  input  logic        irq_int_i,
  input  logic [31:0] boot_addr_i,
  input  logic [31:0] branch_target_i,
  input  logic [31:0] csr_mepc_i,
  input  logic [31:0] csr_depc_i,
  input  logic [31:0] csr_mtvec_i,
  output logic [31:0] fetch_target_o,
  output logic        csr_mtvec_init_o
);

  logic [4:0]  irq_vec;
  logic [31:0] exc_pc;
  logic [31:0] next_pc;

  //////////////////////////////////////////////////
  // exception pc
  //////////////////////////////////////////////////

  // internal interrupts are steered onto the nmi slot
  assign irq_vec = irq_int_i ? IRQ_NM_VEC : irq_vec_i;

  always_comb begin
    unique case (exc_pc_mux_i)
      // synchronous traps land on the 256 byte aligned base
      EXC_PC_EXC:     exc_pc = {csr_mtvec_i[31:8], 8'h00};
      // vectored mode, base plus one word per cause
      EXC_PC_IRQ:     exc_pc = {csr_mtvec_i[31:8], 1'b0, irq_vec, 2'b00};
      EXC_PC_DBD:     exc_pc = DM_HALT_ADDR;
      EXC_PC_DBG_EXC: exc_pc = DM_EXC_ADDR;
      default:        exc_pc = {csr_mtvec_i[31:8], 8'h00};
    endcase
  end

  //////////////////////////////////////////////////
  // fetch target
  //////////////////////////////////////////////////

  always_comb begin
    unique case (pc_mux_i)
      PC_BOOT: next_pc = boot_addr_i;
      PC_JUMP: next_pc = branch_target_i;
      PC_EXC:  next_pc = exc_pc;
      // return from trap handler
      PC_ERET: next_pc = csr_mepc_i;
      // return from debug mode
      PC_DRET: next_pc = csr_depc_i;
      default: next_pc = boot_addr_i;
    endcase
  end

  // no compressed support, drop the halfword bits
  assign fetch_target_o = {next_pc[31:2], 2'b00};

  // csr file loads mtvec from the boot address on this pulse
  assign csr_mtvec_init_o = pc_set_i & (pc_mux_i == PC_BOOT);

endmodule

//--- verilog/if_stage.sv
//////////////////////////////////////////////////
// instruction fetch stage top level
// pc selection, fetch unit and IF-ID register
//////////////////////////////////////////////////

`timescale 1ns/100ps

module if_stage import if_ctrl_pkg::*, if_bus_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,

  // next-pc sources and controls
  input  logic [31:0] boot_addr_i,
  input  logic        pc_set_i,
  input  pc_sel_e     pc_mux_i,
  input  exc_pc_sel_e exc_pc_mux_i,
  input  logic [4:0]  irq_vec_i,
  input  logic        irq_int_i,
  input  logic [31:0] branch_target_ex_i,
  input  logic [31:0] csr_mepc_i,
  input  logic [31:0] csr_depc_i,
  input  logic [31:0] csr_mtvec_i,
  output logic [31:0] pc_set_target_o,
  output logic        csr_mtvec_init_o,

  // instruction bus
  output instr_req_t  instr_req_o,
  input  instr_rsp_t  instr_rsp_i,

  // ID side
  input  logic        id_in_ready_i,
  input  logic        instr_valid_clear_i,
  output logic        instr_valid_id_o,
  output logic        instr_new_id_o,
  output logic        instr_fetch_err_o,
  output logic [31:0] instr_rdata_id_o,
  output logic [31:0] pc_id_o,

  // status
  output logic        pc_mismatch_alert_o,
  output logic        if_busy_o
);

  // fetched word on its way to the IF-ID register
  fetch_out_t fetch_out;

  //////////////////////////////////////////////////
  // pc selection
  //////////////////////////////////////////////////

  if_pc_select pc_select_inst (
    .pc_mux_i         (pc_mux_i),
    .pc_set_i         (pc_set_i),
    .exc_pc_mux_i     (exc_pc_mux_i),
    .irq_vec_i        (irq_vec_i),
    .irq_int_i        (irq_int_i),
    .boot_addr_i      (boot_addr_i),
    .branch_target_i  (branch_target_ex_i),
    .csr_mepc_i       (csr_mepc_i),
    .csr_depc_i       (csr_depc_i),
    .csr_mtvec_i      (csr_mtvec_i),
    .fetch_target_o   (pc_set_target_o),
    .csr_mtvec_init_o (csr_mtvec_init_o)
  );

  //////////////////////////////////////////////////
  // fetch and IF-ID
  //////////////////////////////////////////////////

  if_fetch_unit fetch_unit_inst (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .redirect_i (pc_set_i),
    .target_i   (pc_set_target_o),
    .bus_rsp_i  (instr_rsp_i),
    .ready_i    (id_in_ready_i),
    .bus_req_o  (instr_req_o),
    .fetch_o    (fetch_out),
    .busy_o     (if_busy_o)
  );

  if_id_register id_register_inst (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .fetch_i             (fetch_out),
    .id_in_ready_i       (id_in_ready_i),
    .pc_set_i            (pc_set_i),
    .instr_valid_clear_i (instr_valid_clear_i),
    .instr_valid_id_o    (instr_valid_id_o),
    .instr_new_id_o      (instr_new_id_o),
    .instr_fetch_err_o   (instr_fetch_err_o),
    .instr_rdata_id_o    (instr_rdata_id_o),
    .pc_id_o             (pc_id_o),
    .pc_mismatch_alert_o (pc_mismatch_alert_o)
  );

endmodule
